//--- src.f
mcu_link_pkg.sv
obi_link_initiator.sv
link_tx.sv
link_rx.sv
link_target.sv
mcu_link_top.sv
mcu_link_props.sv
tb_mcu_link.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= tb_mcu_link
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_mcu_link.sv
/* testbench for the mcu link bridge
   OBI traffic through the looped-back serial link, checked against a shadow memory */

`timescale 1ns/10ps

module tb_mcu_link;

  localparam int GRANT_LIMIT = 200;
  localparam int IDLE_LIMIT = 4000;
  localparam int STALL_CYCLES = 60;

  logic                                clk;
  logic                                reset;
  logic                                obi_req;
  logic [31:0]                         obi_addr;
  logic                                obi_we;
  logic [mcu_link_pkg::BE_W-1:0]       obi_be;
  logic [mcu_link_pkg::DATA_W-1:0]     obi_wdata;
  logic                                obi_gnt;
  logic                                obi_rvalid;
  logic [mcu_link_pkg::DATA_W-1:0]     obi_rdata;
  logic                                lane_valid;
  logic [mcu_link_pkg::NUM_LANES-1:0]  lane_data;
  logic                                credit_ret;
  logic                                credit_back;

  logic [31:0] shadow [16];
  logic [31:0] exp_data [$];
  bit          exp_read [$];
  int          credit_due [$];
  logic [31:0] stim_state;
  logic [31:0] delay_state;
  string       test_name;
  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          grants = 0;
  int          rsps = 0;
  int          test_errors = 0;
  bit          hold_credits = 1'b0;
  bit          rand_delay = 1'b0;
  bit          aborted = 1'b0;

  mcu_link_top dut0 (
    .clk_i       (clk),
    .reset_i     (reset),
    .obi_req_i   (obi_req),
    .obi_addr_i  (obi_addr),
    .obi_we_i    (obi_we),
    .obi_be_i    (obi_be),
    .obi_wdata_i (obi_wdata),
    .obi_gnt_o   (obi_gnt),
    .obi_rvalid_o(obi_rvalid),
    .obi_rdata_o (obi_rdata),
    .lane_valid_o(lane_valid),
    .lane_data_o (lane_data),
    .lane_valid_i(lane_valid),
    .lane_data_i (lane_data),
    .credit_o    (credit_ret),
    .credit_i    (credit_back)
  );

  bind mcu_link_top mcu_link_props props0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .obi_req_i   (obi_req_i),
    .obi_gnt_o   (obi_gnt_o),
    .obi_rvalid_o(obi_rvalid_o),
    .lane_valid_o(lane_valid_o),
    .credit_i    (credit_i)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_stim();
    stim_state = xorshift(stim_state);
    return stim_state;
  endfunction

  function automatic bit busy();
    return (exp_data.size() != 0) || (!hold_credits && credit_due.size() != 0) ||
           (lane_valid === 1'b1);
  endfunction

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // credit loopback with its own delay per pulse
  always @(negedge clk) begin
    if (!reset && credit_ret === 1'b1) begin
      if (rand_delay) begin
        delay_state = xorshift(delay_state);
        credit_due.push_back(cycle + int'(delay_state[2:0]));
      end else begin
        credit_due.push_back(cycle);
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle) begin
      credit_back <= 1'b1;
      void'(credit_due.pop_front());
    end else begin
      credit_back <= 1'b0;
    end
  end

  always @(negedge clk) begin : rsp_monitor
    logic [31:0] want;
    bit          is_read;
    if (!reset && obi_rvalid === 1'b1) begin
      rsps++;
      checks++;
      assert (exp_data.size() > 0) else begin
        $display("%s: response without an outstanding request", test_name);
        errors++;
      end
      if (exp_data.size() > 0) begin
        want = exp_data.pop_front();
        is_read = exp_read.pop_front();
        if (is_read) begin
          checks++;
          assert (obi_rdata === want) else begin
            $display("mismatch %s: expected %h actual %h", test_name, want, obi_rdata);
            errors++;
          end
        end
      end
    end
  end

  task automatic timeout_fail(input string what);
    $display("%s: timed out, %s", test_name, what);
    errors++;
    aborted = 1'b1;
  endtask

  task automatic drive_req(input bit we, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    @(posedge clk);
    obi_req <= 1'b1;
    obi_we <= we;
    obi_addr <= addr;
    obi_be <= be;
    obi_wdata <= wdata;
  endtask

  // books the expected response at the grant
  task automatic await_grant();
    int         waited;
    logic [3:0] idx;
    waited = 0;
    @(negedge clk);
    while (obi_gnt !== 1'b1 && waited < GRANT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (obi_gnt !== 1'b1) begin
      timeout_fail("request never granted");
    end else begin
      idx = obi_addr[5:2];
      exp_data.push_back(shadow[idx]);
      exp_read.push_back(!obi_we);
      grants++;
      for (int b = 0; b < 4; b++) begin
        if (obi_we && obi_be[b]) begin
          shadow[idx][8*b +: 8] = obi_wdata[8*b +: 8];
        end
      end
    end
    @(posedge clk);
    obi_req <= 1'b0;
  endtask

  task automatic issue(input bit we, input logic [31:0] addr, input logic [3:0] be,
                       input logic [31:0] wdata);
    if (aborted) return;
    drive_req(we, addr, be, wdata);
    await_grant();
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (busy() && !aborted && waited < IDLE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (busy() && !aborted) begin
      timeout_fail("responses or credits still pending");
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("%-14s %s", test_name, (errors == test_errors) ? "ok" : "had errors");
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    stim_state = 32'hdbc7_47e6;
    delay_state = xorshift(32'hdbc7_47e6 ^ 32'h5a5a_5a5a);
    for (int i = 0; i < 16; i++) begin
      shadow[i] = '0;
    end
    reset = 1'b1;
    obi_req = 1'b0;
    obi_addr = '0;
    obi_we = 1'b0;
    obi_be = '0;
    obi_wdata = '0;
    credit_back = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    start_test("reset");
    @(negedge clk);
    checks++;
    assert ({lane_valid, credit_ret, obi_rvalid} === 3'b000) else begin
      $display("mismatch %s: expected %b actual %b", test_name, 3'b000,
               {lane_valid, credit_ret, obi_rvalid});
      errors++;
    end
    for (int i = 0; i < 16; i++) begin
      issue(1'b0, 32'(i) << 2, 4'h0, '0);
    end
    wait_idle();
    end_test();

    start_test("full_write");
    for (int i = 0; i < 16; i++) begin
      issue(1'b1, 32'(i) << 2, 4'hf, next_stim());
    end
    for (int i = 0; i < 16; i++) begin
      issue(1'b0, 32'(i) << 2, 4'h0, '0);
    end
    wait_idle();
    end_test();

    start_test("byte_enable");
    for (int i = 0; i < 40; i++) begin
      r = next_stim();
      issue(1'b1, {26'd0, r[3:0], 2'b00}, r[7:4], next_stim());
    end
    for (int i = 0; i < 16; i++) begin
      issue(1'b0, 32'(i) << 2, 4'h0, '0);
    end
    wait_idle();
    end_test();

    // warm-up read leaves two credits for the write and read after it
    start_test("credit_stall");
    hold_credits = 1'b1;
    issue(1'b0, 32'h0, 4'h0, '0);
    wait_idle();
    issue(1'b1, 32'h4, 4'hf, 32'hc0de_0001);
    issue(1'b0, 32'h4, 4'h0, '0);
    if (!aborted) begin
      drive_req(1'b0, 32'h8, 4'h0, '0);
      repeat (STALL_CYCLES) begin
        @(negedge clk);
        checks++;
        assert ({obi_gnt, obi_rvalid} === 2'b00) else begin
          $display("mismatch %s: expected %b actual %b", test_name, 2'b00,
                   {obi_gnt, obi_rvalid});
          errors++;
        end
      end
      hold_credits = 1'b0;
      await_grant();
    end
    hold_credits = 1'b0;
    wait_idle();
    end_test();

    start_test("random");
    rand_delay = 1'b1;
    for (int i = 0; i < 200; i++) begin
      r = next_stim();
      a = next_stim();
      issue(r[0], {a[31:6], r[4:1], a[1:0]}, r[11:8], next_stim());
    end
    wait_idle();
    checks++;
    assert (rsps == grants) else begin
      $display("mismatch %s: expected %0d actual %0d", test_name, grants, rsps);
      errors++;
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- mcu_link_props.sv
/* link properties
   credit budget on the outbound lanes and OBI response accounting */

`timescale 1ns/10ps

module mcu_link_props (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  obi_req_i,
  input  logic  obi_gnt_o,
  input  logic  obi_rvalid_o,
  input  logic  lane_valid_o,
  input  logic  credit_i
);

  int    beat_q;
  int    starts_q;
  int    credits_q;
  int    grants_q;
  int    rvalids_q;
  logic  first_beat;

  // packets run back to back, so count beats to find each start
  assign first_beat = lane_valid_o && (beat_q == 0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_q <= 0;
      starts_q <= 0;
      credits_q <= 0;
      grants_q <= 0;
      rvalids_q <= 0;
    end else begin
      if (lane_valid_o) begin
        beat_q <= (beat_q == mcu_link_pkg::BEATS - 1) ? 0 : beat_q + 1;
      end
      if (first_beat) begin
        starts_q <= starts_q + 1;
      end
      if (credit_i) begin
        credits_q <= credits_q + 1;
      end
      if (obi_req_i && obi_gnt_o) begin
        grants_q <= grants_q + 1;
      end
      if (obi_rvalid_o) begin
        rvalids_q <= rvalids_q + 1;
      end
    end
  end

  credit_budget: assert property (@(posedge clk_i) disable iff (reset_i)
    (starts_q - credits_q) <= mcu_link_pkg::LINK_CREDITS)
    else $error("more packets started than credits allow");

  rsp_count: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_rvalid_o |-> (rvalids_q < grants_q))
    else $error("rvalid without a granted request");

  gnt_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_gnt_o |-> ((grants_q - rvalids_q) < mcu_link_pkg::MAX_OUTSTANDING))
    else $error("grant with the outstanding limit reached");

endmodule

//--- mcu_link_top.sv
/* mcu link top
   OBI port to serial link and back through the link-side target,
   lanes and credits leave the chip for the loopback */

`timescale 1ns/10ps

module mcu_link_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  // OBI port
  input  logic                                obi_req_i,
  input  logic [31:0]                         obi_addr_i,
  input  logic                                obi_we_i,
  input  logic [mcu_link_pkg::BE_W-1:0]       obi_be_i,
  input  logic [mcu_link_pkg::DATA_W-1:0]     obi_wdata_i,
  output logic                                obi_gnt_o,
  output logic                                obi_rvalid_o,
  output logic [mcu_link_pkg::DATA_W-1:0]     obi_rdata_o,
  // serial link
  output logic                                lane_valid_o,
  output logic [mcu_link_pkg::NUM_LANES-1:0]  lane_data_o,
  input  logic                                lane_valid_i,
  input  logic [mcu_link_pkg::NUM_LANES-1:0]  lane_data_i,
  output logic                                credit_o,
  input  logic                                credit_i
);

  logic                              req_pkt_valid;
  logic                              req_pkt_ready;
  logic [mcu_link_pkg::PKT_W-1:0]    req_pkt;
  logic                              rsp_pkt_valid;
  logic                              rsp_pkt_ready;
  logic [mcu_link_pkg::PKT_W-1:0]    rsp_pkt;
  logic                              tgt_pkt_valid;
  logic                              tgt_pkt_ready;
  logic [mcu_link_pkg::PKT_W-1:0]    tgt_pkt;
  logic                              rsp_in_valid;
  logic                              rsp_in_ready;
  logic [mcu_link_pkg::DATA_W-1:0]   rsp_in_data;

  obi_link_initiator initiator_i (
    .clk_i,
    .reset_i,
    .obi_req_i,
    .obi_addr_i,
    .obi_we_i,
    .obi_be_i,
    .obi_wdata_i,
    .obi_gnt_o,
    .obi_rvalid_o,
    .obi_rdata_o,
    .req_pkt_valid_o(req_pkt_valid),
    .req_pkt_o      (req_pkt),
    .req_pkt_ready_i(req_pkt_ready),
    .rsp_in_valid_i (rsp_in_valid),
    .rsp_in_data_i  (rsp_in_data),
    .rsp_in_ready_o (rsp_in_ready)
  );

  link_tx link_tx_i (
    .clk_i,
    .reset_i,
    .req_pkt_valid_i(req_pkt_valid),
    .req_pkt_i      (req_pkt),
    .req_pkt_ready_o(req_pkt_ready),
    .rsp_pkt_valid_i(rsp_pkt_valid),
    .rsp_pkt_i      (rsp_pkt),
    .rsp_pkt_ready_o(rsp_pkt_ready),
    .credit_i,
    .lane_valid_o,
    .lane_data_o
  );

  link_rx link_rx_i (
    .clk_i,
    .reset_i,
    .lane_valid_i,
    .lane_data_i,
    .credit_o,
    .tgt_pkt_valid_o(tgt_pkt_valid),
    .tgt_pkt_o      (tgt_pkt),
    .tgt_pkt_ready_i(tgt_pkt_ready),
    .rsp_in_valid_o (rsp_in_valid),
    .rsp_in_data_o  (rsp_in_data),
    .rsp_in_ready_i (rsp_in_ready)
  );

  link_target link_target_i (
    .clk_i,
    .reset_i,
    .tgt_pkt_valid_i(tgt_pkt_valid),
    .tgt_pkt_i      (tgt_pkt),
    .tgt_pkt_ready_o(tgt_pkt_ready),
    .rsp_pkt_valid_o(rsp_pkt_valid),
    .rsp_pkt_o      (rsp_pkt),
    .rsp_pkt_ready_i(rsp_pkt_ready)
  );

endmodule

//--- link_target.sv
/* link target
   16-word register file behind the link, executes request packets
   and answers each with one response packet */

`timescale 1ns/10ps

module link_target (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            tgt_pkt_valid_i,
  input  logic [mcu_link_pkg::PKT_W-1:0]  tgt_pkt_i,
  output logic                            tgt_pkt_ready_o,
  output logic                            rsp_pkt_valid_o,
  output logic [mcu_link_pkg::PKT_W-1:0]  rsp_pkt_o,
  input  logic                            rsp_pkt_ready_i
);

  logic [mcu_link_pkg::DATA_W-1:0]  regs_q [mcu_link_pkg::TARGET_WORDS];
  logic                             rsp_valid_q;
  logic [mcu_link_pkg::PKT_W-1:0]   rsp_pkt_q;
  logic                             accept;
  mcu_link_pkg::pkt_kind_e          req_kind;
  logic [mcu_link_pkg::IDX_W-1:0]   req_idx;
  logic [mcu_link_pkg::BE_W-1:0]    req_be;
  logic [mcu_link_pkg::DATA_W-1:0]  req_wdata;

  assign req_kind = mcu_link_pkg::pkt_kind_e'(
                      tgt_pkt_i[mcu_link_pkg::KIND_LSB +: mcu_link_pkg::KIND_W]);
  assign req_idx = tgt_pkt_i[mcu_link_pkg::IDX_LSB +: mcu_link_pkg::IDX_W];
  assign req_be = tgt_pkt_i[mcu_link_pkg::BE_LSB +: mcu_link_pkg::BE_W];
  assign req_wdata = tgt_pkt_i[mcu_link_pkg::DATA_LSB +: mcu_link_pkg::DATA_W];

  // only one response in flight
  assign tgt_pkt_ready_o = !rsp_valid_q;
  assign accept = tgt_pkt_valid_i && tgt_pkt_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int w = 0; w < mcu_link_pkg::TARGET_WORDS; w++) begin
        regs_q[w] <= '0;
      end
    end else if (accept && (req_kind == mcu_link_pkg::PKT_WRITE)) begin
      for (int b = 0; b < mcu_link_pkg::BE_W; b++) begin
        if (req_be[b]) begin
          regs_q[req_idx][8*b +: 8] <= req_wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_pkt_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // reads return the word, writes return the word before the merge
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_pkt_q <= {{mcu_link_pkg::PAD_W{1'b0}}, mcu_link_pkg::PKT_RSP, req_be, req_idx,
                    regs_q[req_idx]};
    end
  end

  assign rsp_pkt_valid_o = rsp_valid_q;
  assign rsp_pkt_o = rsp_pkt_q;

endmodule

//--- link_rx.sv
/* link receiver
   gathers lane beats into packets, queues them in the credit fifo and
   hands the head to the initiator or the target by packet kind */

`timescale 1ns/10ps

module link_rx (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                lane_valid_i,
  input  logic [mcu_link_pkg::NUM_LANES-1:0]  lane_data_i,
  output logic                                credit_o,
  output logic                                tgt_pkt_valid_o,
  output logic [mcu_link_pkg::PKT_W-1:0]      tgt_pkt_o,
  input  logic                                tgt_pkt_ready_i,
  output logic                                rsp_in_valid_o,
  output logic [mcu_link_pkg::DATA_W-1:0]     rsp_in_data_o,
  input  logic                                rsp_in_ready_i
);

  logic [mcu_link_pkg::BEAT_W-1:0]      beat_q;
  logic [mcu_link_pkg::PKT_W-1:0]       gather_q;
  logic [mcu_link_pkg::PKT_W-1:0]       beat_word;
  logic [mcu_link_pkg::PKT_W-1:0]       fifo_q [mcu_link_pkg::LINK_CREDITS];
  logic [mcu_link_pkg::FIFO_PTR_W-1:0]  wr_ptr_q;
  logic [mcu_link_pkg::FIFO_PTR_W-1:0]  rd_ptr_q;
  logic [mcu_link_pkg::CREDIT_W-1:0]    count_q;
  logic [mcu_link_pkg::PKT_W-1:0]       head_pkt;
  mcu_link_pkg::pkt_kind_e              head_kind;
  logic                                 last_beat;
  logic                                 head_valid;
  logic                                 head_is_rsp;
  logic                                 pop;

  assign last_beat = lane_valid_i &&
                     (beat_q == mcu_link_pkg::BEAT_W'(mcu_link_pkg::BEATS - 1));

  // new beat enters at the top, so the first beat ends up lowest
  assign beat_word = {lane_data_i, gather_q[mcu_link_pkg::PKT_W-1:mcu_link_pkg::NUM_LANES]};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_q <= '0;
    end else if (lane_valid_i) begin
      beat_q <= last_beat ? '0 : beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_valid_i) begin
      gather_q <= beat_word;
    end
  end

  // full packet written straight from the last beat
  always_ff @(posedge clk_i) begin
    if (last_beat) begin
      fifo_q[wr_ptr_q] <= beat_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (last_beat) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + mcu_link_pkg::CREDIT_W'(last_beat)
                 - mcu_link_pkg::CREDIT_W'(pop);
    end
  end

  assign head_valid = (count_q != '0);
  assign head_pkt = fifo_q[rd_ptr_q];
  assign head_kind = mcu_link_pkg::pkt_kind_e'(
                       head_pkt[mcu_link_pkg::KIND_LSB +: mcu_link_pkg::KIND_W]);
  assign head_is_rsp = (head_kind == mcu_link_pkg::PKT_RSP);

  assign tgt_pkt_valid_o = head_valid && !head_is_rsp;
  assign tgt_pkt_o = head_pkt;
  assign rsp_in_valid_o = head_valid && head_is_rsp;
  assign rsp_in_data_o = head_pkt[mcu_link_pkg::DATA_LSB +: mcu_link_pkg::DATA_W];

  assign pop = (tgt_pkt_valid_o && tgt_pkt_ready_i) ||
               (rsp_in_valid_o && rsp_in_ready_i);

  // one credit back per freed entry
  assign credit_o = pop;

endmodule

//--- link_tx.sv
/* link transmitter
   picks response packets over request packets and shifts each one out
   over the lanes, one credit spent per packet */

`timescale 1ns/10ps

module link_tx (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                req_pkt_valid_i,
  input  logic [mcu_link_pkg::PKT_W-1:0]      req_pkt_i,
  output logic                                req_pkt_ready_o,
  input  logic                                rsp_pkt_valid_i,
  input  logic [mcu_link_pkg::PKT_W-1:0]      rsp_pkt_i,
  output logic                                rsp_pkt_ready_o,
  input  logic                                credit_i,
  output logic                                lane_valid_o,
  output logic [mcu_link_pkg::NUM_LANES-1:0]  lane_data_o
);

  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_e;

  tx_state_e                            state_q;
  logic [mcu_link_pkg::BEAT_W-1:0]      beat_q;
  logic [mcu_link_pkg::PKT_W-1:0]       shift_q;
  logic [mcu_link_pkg::CREDIT_W-1:0]    credit_q;
  logic                                 last_beat;
  logic                                 can_start;
  logic                                 take_rsp;
  logic                                 take_req;
  logic                                 start;

  assign last_beat = (state_q == TX_SEND) &&
                     (beat_q == mcu_link_pkg::BEAT_W'(mcu_link_pkg::BEATS - 1));

  // a new packet may follow the last beat directly
  assign can_start = ((state_q == TX_IDLE) || last_beat) && (credit_q != '0);

  // fixed priority, responses first
  assign rsp_pkt_ready_o = can_start;
  assign req_pkt_ready_o = can_start && !rsp_pkt_valid_i;

  assign take_rsp = rsp_pkt_valid_i && rsp_pkt_ready_o;
  assign take_req = req_pkt_valid_i && req_pkt_ready_o;
  assign start = take_rsp || take_req;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= TX_IDLE;
      beat_q <= '0;
    end else if (start) begin
      state_q <= TX_SEND;
      beat_q <= '0;
    end else if (last_beat) begin
      state_q <= TX_IDLE;
    end else if (state_q == TX_SEND) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // low lanes go first
  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_q <= take_rsp ? rsp_pkt_i : req_pkt_i;
    end else if (state_q == TX_SEND) begin
      shift_q <= shift_q >> mcu_link_pkg::NUM_LANES;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_q <= mcu_link_pkg::CREDIT_W'(mcu_link_pkg::LINK_CREDITS);
    end else begin
      credit_q <= credit_q + mcu_link_pkg::CREDIT_W'(credit_i)
                  - mcu_link_pkg::CREDIT_W'(start);
    end
  end

  assign lane_valid_o = (state_q == TX_SEND);
  assign lane_data_o = shift_q[mcu_link_pkg::NUM_LANES-1:0];

endmodule

//--- obi_link_initiator.sv
/* OBI link initiator
   grants OBI requests into a one-entry packet slot and turns returning
   response packets into in-order rvalid pulses */

`timescale 1ns/10ps

module obi_link_initiator (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              obi_req_i,
  input  logic [31:0]                       obi_addr_i,
  input  logic                              obi_we_i,
  input  logic [mcu_link_pkg::BE_W-1:0]     obi_be_i,
  input  logic [mcu_link_pkg::DATA_W-1:0]   obi_wdata_i,
  output logic                              obi_gnt_o,
  output logic                              obi_rvalid_o,
  output logic [mcu_link_pkg::DATA_W-1:0]   obi_rdata_o,
  output logic                              req_pkt_valid_o,
  output logic [mcu_link_pkg::PKT_W-1:0]    req_pkt_o,
  input  logic                              req_pkt_ready_i,
  input  logic                              rsp_in_valid_i,
  input  logic [mcu_link_pkg::DATA_W-1:0]   rsp_in_data_i,
  output logic                              rsp_in_ready_o
);

  logic                              slot_valid_q;
  logic [mcu_link_pkg::PKT_W-1:0]    slot_pkt_q;
  logic [mcu_link_pkg::OUT_W-1:0]    out_cnt_q;
  logic                              rvalid_q;
  logic [mcu_link_pkg::DATA_W-1:0]   rdata_q;
  logic                              grant;
  logic                              rsp_take;
  mcu_link_pkg::pkt_kind_e           req_kind;

  // responses are never back-pressured
  assign rsp_in_ready_o = 1'b1;
  assign rsp_take = rsp_in_valid_i && rsp_in_ready_o;

  assign grant = obi_req_i && !slot_valid_q &&
                 (out_cnt_q < mcu_link_pkg::OUT_W'(mcu_link_pkg::MAX_OUTSTANDING));
  assign obi_gnt_o = grant;

  assign req_kind = obi_we_i ? mcu_link_pkg::PKT_WRITE : mcu_link_pkg::PKT_READ;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_valid_q <= 1'b0;
    end else if (grant) begin
      slot_valid_q <= 1'b1;
    end else if (req_pkt_ready_i) begin
      slot_valid_q <= 1'b0;
    end
  end

  // word index from address bits 5:2
  always_ff @(posedge clk_i) begin
    if (grant) begin
      slot_pkt_q <= {{mcu_link_pkg::PAD_W{1'b0}}, req_kind, obi_be_i,
                     obi_addr_i[2 +: mcu_link_pkg::IDX_W], obi_wdata_i};
    end
  end

  assign req_pkt_valid_o = slot_valid_q;
  assign req_pkt_o = slot_pkt_q;

  // outstanding = granted but rvalid not yet seen on the bus
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_cnt_q <= '0;
    end else if (grant && !rvalid_q) begin
      out_cnt_q <= out_cnt_q + 1'b1;
    end else if (!grant && rvalid_q) begin
      out_cnt_q <= out_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rsp_take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_take) begin
      rdata_q <= rsp_in_data_i;
    end
  end

  assign obi_rvalid_o = rvalid_q;
  assign obi_rdata_o = rdata_q;

endmodule

//--- mcu_link_pkg.sv
/* mcu link package
   lane geometry, packet layout, packet kinds and flow control limits
   shared by the OBI to serial link bridge */

package mcu_link_pkg;

  // bus side
  localparam int DATA_W = 32;
  localparam int BE_W = 4;
  localparam int IDX_W = 4;
  localparam int TARGET_WORDS = 16;

  // serial lanes, single data rate
  localparam int NUM_LANES = 4;

  // packet fields, data in the low bits
  localparam int KIND_W = 2;
  localparam int DATA_LSB = 0;
  localparam int IDX_LSB = DATA_LSB + DATA_W;
  localparam int BE_LSB = IDX_LSB + IDX_W;
  localparam int KIND_LSB = BE_LSB + BE_W;
  localparam int FIELD_W = KIND_LSB + KIND_W;

  // rounded up to whole lane beats
  localparam int PKT_W = ((FIELD_W + NUM_LANES - 1) / NUM_LANES) * NUM_LANES;
  localparam int PAD_W = PKT_W - FIELD_W;
  localparam int BEATS = PKT_W / NUM_LANES;
  localparam int BEAT_W = $clog2(BEATS);

  // credits per link direction, equal to the rx fifo depth
  localparam int LINK_CREDITS = 4;
  localparam int CREDIT_W = $clog2(LINK_CREDITS + 1);
  localparam int FIFO_PTR_W = $clog2(LINK_CREDITS);

  // requests and responses share one rx fifo on the loopback,
  // half of it per kind keeps both moving
  localparam int MAX_OUTSTANDING = LINK_CREDITS / 2;
  localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);

  typedef enum logic [KIND_W-1:0] {
    PKT_WRITE = 2'd0,
    PKT_READ  = 2'd1,
    PKT_RSP   = 2'd2
  } pkt_kind_e;

endpackage
